// File: bench/norm_check_assert.sv
/* Concurrent checks on the norm-check controller FSM and its read sequence */

`timescale 1ns/10ps

module norm_check_assert (
    input logic                            clk,
    input logic                            reset_n,
    input logic                            zeroize,
    input logic                            norm_check_enable,
    input logic                            mem_rd_en,
    input logic                            ctrl_done,
    input norm_check_pkg::chk_read_state_e state
);

    logic [6:0] rd_seen;
    logic       active;

    // Reads issued since the last accepted enable
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_seen <= '0;
        end else if (zeroize) begin
            rd_seen <= '0;
        end else if (state == norm_check_pkg::CHK_IDLE && norm_check_enable) begin
            rd_seen <= '0;
        end else if (mem_rd_en) begin
            rd_seen <= rd_seen + 7'd1;
        end
    end

    // A check runs from an accepted enable until ctrl_done or zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active <= 1'b0;
        end else if (zeroize) begin
            active <= 1'b0;
        end else if (ctrl_done) begin
            active <= 1'b0;
        end else if (norm_check_enable && !active) begin
            active <= 1'b1;
        end
    end

    rd_en_not_idle: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_en |-> active)
        else $error("read enable high while no check is running");

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        ctrl_done |=> !ctrl_done)
        else $error("ctrl_done held for more than one cycle");

    reads_per_poly: assert property (@(posedge clk) disable iff (!reset_n)
        ctrl_done |-> rd_seen == 7'(norm_check_pkg::WORDS_PER_POLY))
        else $error("ctrl_done after %0d reads instead of one full polynomial", rd_seen);

endmodule

bind norm_check_ctrl norm_check_assert ctrl_assert0 (
    .clk               (clk),
    .reset_n           (reset_n),
    .zeroize           (zeroize),
    .norm_check_enable (norm_check_enable),
    .mem_rd_en         (mem_rd_en),
    .ctrl_done         (ctrl_done),
    .state             (state)
);

// File: bench/norm_check_tb.sv
/* Testbench for the norm-check subsystem: clock, reset, stimulus table,
   reference model, checks and watchdog */

`timescale 1ns/10ps

module norm_check_tb;

    localparam int LATENCY    = 66;
    localparam int DONE_LIMIT = 100;
    localparam int QUIET_WAIT = 80;
    localparam int ROW_CYCLES = norm_check_pkg::WORDS_PER_POLY + LATENCY + 20;
    localparam int RESET_CYC  = 8;
    localparam int NO_ZEROIZE = -1;

    typedef enum int {
        FILL_IN_RANGE, FILL_AT_BOUND, FILL_BELOW_BOUND, FILL_NEG_BOUND, FILL_KEEP
    } fill_e;

    logic                        clk;
    logic                        reset_n;
    logic                        zeroize;
    logic                        norm_check_enable;
    logic [5:0]                  randomness;
    norm_check_pkg::mem_addr_t   mem_base_addr;
    norm_check_pkg::check_mode_e check_mode;
    logic                        mem_wr_en;
    norm_check_pkg::mem_addr_t   mem_wr_addr;
    norm_check_pkg::mem_word_t   mem_wr_data;
    logic                        norm_check_done;
    logic                        norm_check_invalid;

    // Stimulus table, one entry per test in each queue
    string                       t_name [$];
    norm_check_pkg::check_mode_e t_mode [$];
    int                          t_base [$];
    int                          t_rnd  [$];
    fill_e                       t_fill [$];
    int                          t_pos  [$];
    int                          t_zcyc [$];
    bit                          t_exp  [$];

    // Copy of what the testbench wrote into the coefficient memory
    norm_check_pkg::mem_word_t shadow [norm_check_pkg::MEM_DEPTH];
    int n_pass;
    int n_fail;
    bit table_built;

    norm_check_top dut0 (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize            (zeroize),
        .norm_check_enable  (norm_check_enable),
        .randomness         (randomness),
        .mem_base_addr      (mem_base_addr),
        .check_mode         (check_mode),
        .mem_wr_en          (mem_wr_en),
        .mem_wr_addr        (mem_wr_addr),
        .mem_wr_data        (mem_wr_data),
        .norm_check_done    (norm_check_done),
        .norm_check_invalid (norm_check_invalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void add_row(string name, norm_check_pkg::check_mode_e mode, int base,
                                    int rnd, fill_e fill, int pos, int zcyc, bit exp_inv);
        t_name.push_back(name);
        t_mode.push_back(mode);
        t_base.push_back(base);
        t_rnd.push_back(rnd);
        t_fill.push_back(fill);
        t_pos.push_back(pos);
        t_zcyc.push_back(zcyc);
        t_exp.push_back(exp_inv);
    endfunction

    function automatic int calc_bound(norm_check_pkg::check_mode_e mode);
        case (mode)
            norm_check_pkg::MODE_Z:  return int'(norm_check_pkg::GAMMA1) - int'(norm_check_pkg::BETA);
            norm_check_pkg::MODE_R0: return int'(norm_check_pkg::GAMMA2) - int'(norm_check_pkg::BETA);
            default:                 return int'(norm_check_pkg::GAMMA2);
        endcase
    endfunction

    // Distance from zero in the centered representation mod q
    function automatic int centered(int c);
        int q;
        q = int'(norm_check_pkg::MLDSA_Q);
        if (c <= (q - 1) / 2) begin
            return c;
        end
        return q - c;
    endfunction

    // Random coefficient on either side of zero with a centered value below the bound
    function automatic int filler_coeff(int bnd);
        int mag;
        mag = int'($urandom % bnd);
        if (mag != 0 && ($urandom & 1) != 0) begin
            return int'(norm_check_pkg::MLDSA_Q) - mag;
        end
        return mag;
    endfunction

    function automatic int special_coeff(fill_e fill, int bnd);
        case (fill)
            FILL_AT_BOUND:    return bnd;
            FILL_BELOW_BOUND: return bnd - 1;
            default:          return int'(norm_check_pkg::MLDSA_Q) - bnd;
        endcase
    endfunction

    function automatic bit model_invalid(int base, norm_check_pkg::check_mode_e mode);
        norm_check_pkg::mem_word_t word;
        norm_check_pkg::coeff_t    c;
        int bnd;
        bit hit;
        bnd = calc_bound(mode);
        hit = 1'b0;
        for (int w = 0; w < norm_check_pkg::WORDS_PER_POLY; w++) begin
            word = shadow[norm_check_pkg::mem_addr_t'(base + w)];
            for (int l = 0; l < norm_check_pkg::COEFFS_PER_WORD; l++) begin
                c = norm_check_pkg::coeff_t'(word >> (norm_check_pkg::COEFF_WIDTH * l));
                if (centered(int'(c)) >= bnd) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_poly(input int r);
        norm_check_pkg::mem_word_t word;
        norm_check_pkg::mem_addr_t addr;
        int bnd;
        int c;
        bnd = calc_bound(t_mode[r]);
        for (int w = 0; w < norm_check_pkg::WORDS_PER_POLY; w++) begin
            word = '0;
            for (int l = 0; l < norm_check_pkg::COEFFS_PER_WORD; l++) begin
                c = filler_coeff(bnd);
                if (t_fill[r] != FILL_IN_RANGE &&
                    w * norm_check_pkg::COEFFS_PER_WORD + l == t_pos[r]) begin
                    c = special_coeff(t_fill[r], bnd);
                end
                word = word | (norm_check_pkg::mem_word_t'(c) << (norm_check_pkg::COEFF_WIDTH * l));
            end
            addr = norm_check_pkg::mem_addr_t'(t_base[r] + w);
            shadow[addr] = word;
            mem_wr_en    = 1'b1;
            mem_wr_addr  = addr;
            mem_wr_data  = word;
            next_cycle();
        end
        mem_wr_en = 1'b0;
    endtask

    task automatic run_row(input int r);
        int cnt;
        int limit;
        bit seen;
        bit exp_inv;
        bit row_ok;
        row_ok = 1'b1;
        if (t_fill[r] != FILL_KEEP) begin
            load_poly(r);
        end
        // Zeroize clears the result, otherwise the model decides
        exp_inv = (t_zcyc[r] == NO_ZEROIZE) ? model_invalid(t_base[r], t_mode[r]) : 1'b0;
        assert (exp_inv == t_exp[r]) else begin
            $display("Fail %s: table expects invalid %0d, model gives %0d",
                     t_name[r], t_exp[r], exp_inv);
            row_ok = 1'b0;
        end
        check_mode        = t_mode[r];
        mem_base_addr     = norm_check_pkg::mem_addr_t'(t_base[r]);
        randomness        = 6'(t_rnd[r]);
        norm_check_enable = 1'b1;
        cnt   = 0;
        seen  = 1'b0;
        limit = (t_zcyc[r] == NO_ZEROIZE) ? DONE_LIMIT : t_zcyc[r] + QUIET_WAIT;
        while (!seen && cnt < limit) begin
            next_cycle();
            cnt++;
            norm_check_enable = 1'b0;
            zeroize = (cnt == t_zcyc[r]);
            seen = norm_check_done;
        end
        zeroize = 1'b0;
        if (t_zcyc[r] == NO_ZEROIZE) begin
            assert (seen) else begin
                $display("%s: no done pulse within %0d cycles", t_name[r], DONE_LIMIT);
                row_ok = 1'b0;
            end
            if (seen) begin
                assert (cnt == LATENCY) else begin
                    $display("Fail %s: latency expected %0d actual %0d", t_name[r], LATENCY, cnt);
                    row_ok = 1'b0;
                end
                assert (norm_check_invalid == exp_inv) else begin
                    $display("Fail %s: invalid expected %0d actual %0d",
                             t_name[r], exp_inv, norm_check_invalid);
                    row_ok = 1'b0;
                end
            end
        end else begin
            assert (!seen) else begin
                $display("%s: done pulse arrived although the check was zeroized", t_name[r]);
                row_ok = 1'b0;
            end
            assert (norm_check_invalid == 1'b0) else begin
                $display("Fail %s: invalid expected 0 actual %0d", t_name[r], norm_check_invalid);
                row_ok = 1'b0;
            end
        end
        if (row_ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test %-16s %s", t_name[r], row_ok ? "ok" : "failed");
        repeat (2) next_cycle();
    endtask

    initial begin
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        norm_check_enable = 1'b0;
        randomness        = '0;
        mem_base_addr     = '0;
        check_mode        = norm_check_pkg::MODE_Z;
        mem_wr_en         = 1'b0;
        mem_wr_addr       = '0;
        mem_wr_data       = '0;
        n_pass            = 0;
        n_fail            = 0;
        void'($urandom(55449));

        add_row("z_in_range",     norm_check_pkg::MODE_Z,   8'h00, 13, FILL_IN_RANGE,    0,   -1, 0);
        add_row("r0_in_range",    norm_check_pkg::MODE_R0,  8'h40, 40, FILL_IN_RANGE,    0,   -1, 0);
        add_row("ct0_in_range",   norm_check_pkg::MODE_CT0, 8'h80, 7,  FILL_IN_RANGE,    0,   -1, 0);
        add_row("z_at_bound",     norm_check_pkg::MODE_Z,   8'h00, 21, FILL_AT_BOUND,    77,  -1, 1);
        add_row("z_bound_m1",     norm_check_pkg::MODE_Z,   8'h00, 21, FILL_BELOW_BOUND, 77,  -1, 0);
        add_row("r0_at_bound",    norm_check_pkg::MODE_R0,  8'h40, 5,  FILL_AT_BOUND,    130, -1, 1);
        add_row("r0_bound_m1",    norm_check_pkg::MODE_R0,  8'h40, 5,  FILL_BELOW_BOUND, 130, -1, 0);
        add_row("ct0_at_bound",   norm_check_pkg::MODE_CT0, 8'h80, 50, FILL_AT_BOUND,    200, -1, 1);
        add_row("ct0_bound_m1",   norm_check_pkg::MODE_CT0, 8'h80, 50, FILL_BELOW_BOUND, 200, -1, 0);
        add_row("z_neg_bound",    norm_check_pkg::MODE_Z,   8'h00, 33, FILL_NEG_BOUND,   9,   -1, 1);
        add_row("r0_neg_bound",   norm_check_pkg::MODE_R0,  8'h40, 62, FILL_NEG_BOUND,   141, -1, 1);
        add_row("ct0_neg_bound",  norm_check_pkg::MODE_CT0, 8'h80, 18, FILL_NEG_BOUND,   254, -1, 1);
        add_row("first_rnd0",     norm_check_pkg::MODE_R0,  8'h10, 0,  FILL_AT_BOUND,    0,   -1, 1);
        add_row("first_rnd63",    norm_check_pkg::MODE_R0,  8'h10, 63, FILL_KEEP,        0,   -1, 1);
        add_row("first_rnd42",    norm_check_pkg::MODE_R0,  8'h10, 42, FILL_KEEP,        0,   -1, 1);
        add_row("last_rnd63",     norm_check_pkg::MODE_R0,  8'h10, 63, FILL_AT_BOUND,    255, -1, 1);
        add_row("last_rnd0",      norm_check_pkg::MODE_R0,  8'h10, 0,  FILL_KEEP,        0,   -1, 1);
        add_row("base_a_valid",   norm_check_pkg::MODE_Z,   8'h40, 9,  FILL_IN_RANGE,    0,   -1, 0);
        add_row("base_b_wrap",    norm_check_pkg::MODE_Z,   8'hF0, 17, FILL_AT_BOUND,    250, -1, 1);
        add_row("base_a_recheck", norm_check_pkg::MODE_Z,   8'h40, 44, FILL_KEEP,        0,   -1, 0);
        add_row("base_b_recheck", norm_check_pkg::MODE_Z,   8'hF0, 2,  FILL_KEEP,        0,   -1, 1);
        add_row("zeroize_mid",    norm_check_pkg::MODE_Z,   8'h00, 3,  FILL_AT_BOUND,    100, 30, 0);
        add_row("after_zeroize",  norm_check_pkg::MODE_Z,   8'h00, 3,  FILL_KEEP,        0,   -1, 1);
        table_built = 1'b1;

        repeat (RESET_CYC) @(posedge clk);
        #1;
        reset_n = 1'b1;
        next_cycle();

        for (int r = 0; r < t_name.size(); r++) begin
            run_row(r);
        end

        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Budget covers loading, the fixed latency and some slack for every row
    initial begin
        wait (table_built);
        #((t_name.size() * ROW_CYCLES + RESET_CYC + 20) * 8);
        $display("Timeout: the test run did not finish in the expected number of cycles");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the norm-check testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module norm_check_tb -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vnorm_check_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

// File: src/coeff_mem.sv
/* Coefficient word memory with a load port and a registered read port */

`timescale 1ns/10ps

module coeff_mem (
    input  logic                      clk,
    input  logic                      mem_wr_en,
    input  norm_check_pkg::mem_addr_t mem_wr_addr,
    input  norm_check_pkg::mem_word_t mem_wr_data,
    input  logic                      mem_rd_en,
    input  norm_check_pkg::mem_addr_t mem_rd_addr,
    output norm_check_pkg::mem_word_t mem_rd_data
);

    norm_check_pkg::mem_word_t mem_array [norm_check_pkg::MEM_DEPTH];

    // Load port, used to fill polynomials before a check
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem_array[mem_wr_addr] <= mem_wr_data;
        end
    end

    // Read data is available the cycle after the read strobe
    // and holds while no read is issued
    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= mem_array[mem_rd_addr];
        end
    end

endmodule

// File: src/norm_check_ctrl.sv
/* Norm-check controller: FSM and randomized address sequencer issuing
   the 64 word reads of one polynomial */

`timescale 1ns/10ps

module norm_check_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      norm_check_enable,
    input  logic [5:0]                randomness,
    input  norm_check_pkg::mem_addr_t mem_base_addr,
    output logic                      mem_rd_en,
    output norm_check_pkg::mem_addr_t mem_rd_addr,
    output logic                      ctrl_done
);

    norm_check_pkg::chk_read_state_e state, state_nxt;

    norm_check_pkg::mem_addr_t base_addr;
    logic [5:0] rd_offset;
    logic [4:0] hi_cnt;
    logic       rand_lo;
    logic [5:0] rd_cnt;
    logic       last_read;

    // The read counter reaches 63 on the 64th and last read
    assign last_read = (rd_cnt == 6'(norm_check_pkg::WORDS_PER_POLY - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= norm_check_pkg::CHK_IDLE;
        end else if (zeroize) begin
            state <= norm_check_pkg::CHK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            norm_check_pkg::CHK_IDLE: begin
                if (norm_check_enable) begin
                    state_nxt = norm_check_pkg::CHK_RD_MEM;
                end
            end
            norm_check_pkg::CHK_RD_MEM: begin
                state_nxt = norm_check_pkg::CHK_WAIT;
            end
            norm_check_pkg::CHK_WAIT: begin
                state_nxt = last_read ? norm_check_pkg::CHK_DONE : norm_check_pkg::CHK_RD_MEM;
            end
            default: begin
                state_nxt = norm_check_pkg::CHK_IDLE;
            end
        endcase
    end

    // Offset walks pairs {hi_cnt, rand_lo} and {hi_cnt, ~rand_lo}, so the
    // starting point and the pair order both depend on the randomness
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            base_addr <= '0;
            rd_offset <= '0;
            hi_cnt    <= '0;
            rand_lo   <= 1'b0;
            rd_cnt    <= '0;
        end else if (zeroize) begin
            base_addr <= '0;
            rd_offset <= '0;
            hi_cnt    <= '0;
            rand_lo   <= 1'b0;
            rd_cnt    <= '0;
        end else if (state == norm_check_pkg::CHK_IDLE) begin
            if (norm_check_enable) begin
                base_addr <= mem_base_addr;
                rd_offset <= randomness;
                hi_cnt    <= randomness[5:1];
                rand_lo   <= randomness[0];
                rd_cnt    <= '0;
            end
        end else if (state == norm_check_pkg::CHK_RD_MEM) begin
            rd_offset <= {rd_offset[5:1], ~rand_lo};
            hi_cnt    <= hi_cnt + 5'd1;
            rd_cnt    <= rd_cnt + 6'd1;
        end else if (state == norm_check_pkg::CHK_WAIT) begin
            rd_offset <= {hi_cnt, rand_lo};
            rd_cnt    <= rd_cnt + 6'd1;
        end
    end

    // Address wraps modulo the memory size
    assign mem_rd_addr = base_addr + norm_check_pkg::mem_addr_t'(rd_offset);

    assign mem_rd_en = (state == norm_check_pkg::CHK_RD_MEM) ||
                       (state == norm_check_pkg::CHK_WAIT);

    assign ctrl_done = (state == norm_check_pkg::CHK_DONE);

endmodule

// File: src/norm_check_pkg.sv
/* Shared widths, ML-DSA-87 constants, per-mode norm bounds and the
   enums for the check controller and the check mode */

package norm_check_pkg;

    localparam int COEFF_WIDTH     = 24;
    localparam int MEM_ADDR_WIDTH  = 8;
    localparam int MLDSA_N         = 256;
    localparam int COEFFS_PER_WORD = 4;
    localparam int MEM_WORD_WIDTH  = COEFF_WIDTH * COEFFS_PER_WORD;
    localparam int WORDS_PER_POLY  = MLDSA_N / COEFFS_PER_WORD;
    localparam int MEM_DEPTH       = 256;

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [COEFF_WIDTH-1:0]    coeff_t;
    // Coefficient 0 sits in the low 24 bits
    typedef logic [MEM_WORD_WIDTH-1:0] mem_word_t;

    localparam coeff_t MLDSA_Q = 24'd8380417;
    localparam coeff_t HALF_Q  = (MLDSA_Q - 24'd1) >> 1;

    // ML-DSA-87 parameter set
    localparam coeff_t GAMMA1 = 24'd524288;
    localparam coeff_t GAMMA2 = 24'd261888;
    localparam coeff_t BETA   = 24'd120;

    typedef enum logic [1:0] {
        MODE_Z   = 2'd0,
        MODE_R0  = 2'd1,
        MODE_CT0 = 2'd2
    } check_mode_e;

    typedef enum logic [1:0] {
        CHK_IDLE   = 2'd0,
        CHK_RD_MEM = 2'd1,
        CHK_WAIT   = 2'd2,
        CHK_DONE   = 2'd3
    } chk_read_state_e;

    // Bound table; a centered value at or above the bound is a failure
    function automatic coeff_t mode_bound(check_mode_e mode);
        case (mode)
            MODE_Z:  return GAMMA1 - BETA;
            MODE_R0: return GAMMA2 - BETA;
            default: return GAMMA2;
        endcase
    endfunction

endpackage

// File: src/norm_check_top.sv
/* Norm-check subsystem top: controller, coefficient memory and checker */

`timescale 1ns/10ps

module norm_check_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        norm_check_enable,
    input  logic [5:0]                  randomness,
    input  norm_check_pkg::mem_addr_t   mem_base_addr,
    input  norm_check_pkg::check_mode_e check_mode,
    input  logic                        mem_wr_en,
    input  norm_check_pkg::mem_addr_t   mem_wr_addr,
    input  norm_check_pkg::mem_word_t   mem_wr_data,
    output logic                        norm_check_done,
    output logic                        norm_check_invalid
);

    logic                      mem_rd_en;
    norm_check_pkg::mem_addr_t mem_rd_addr;
    norm_check_pkg::mem_word_t mem_rd_data;
    logic                      ctrl_done;

    norm_check_ctrl ctrl0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .randomness        (randomness),
        .mem_base_addr     (mem_base_addr),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .ctrl_done         (ctrl_done)
    );

    coeff_mem mem0 (
        .clk         (clk),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data)
    );

    norm_check_unit chk0 (
        .clk                (clk),
        .reset_n            (reset_n),
        .zeroize            (zeroize),
        .norm_check_enable  (norm_check_enable),
        .check_mode         (check_mode),
        .mem_rd_en          (mem_rd_en),
        .mem_rd_data        (mem_rd_data),
        .ctrl_done          (ctrl_done),
        .norm_check_done    (norm_check_done),
        .norm_check_invalid (norm_check_invalid)
    );

endmodule

// File: src/norm_check_unit.sv
/* Four-lane centered-magnitude compare against the mode bound, with the
   sticky invalid flag and the done pulse aligned to the last compare */

`timescale 1ns/10ps

module norm_check_unit (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        norm_check_enable,
    input  norm_check_pkg::check_mode_e check_mode,
    input  logic                        mem_rd_en,
    input  norm_check_pkg::mem_word_t   mem_rd_data,
    input  logic                        ctrl_done,
    output logic                        norm_check_done,
    output logic                        norm_check_invalid
);

    localparam int LANES = norm_check_pkg::COEFFS_PER_WORD;
    localparam int CW    = norm_check_pkg::COEFF_WIDTH;

    norm_check_pkg::coeff_t bound;
    norm_check_pkg::coeff_t lane_coeff [LANES];
    norm_check_pkg::coeff_t lane_mag   [LANES];
    logic [LANES-1:0]       lane_hit;
    logic                   data_valid;
    logic                   invalid_flag;
    logic                   done_q;

    // Centered magnitude: c for the lower half, q - c for the upper half
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign lane_coeff[i] = mem_rd_data[i*CW +: CW];
        assign lane_mag[i]   = (lane_coeff[i] > norm_check_pkg::HALF_Q) ?
                               norm_check_pkg::MLDSA_Q - lane_coeff[i] : lane_coeff[i];
        assign lane_hit[i]   = (lane_mag[i] >= bound);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bound        <= '0;
            data_valid   <= 1'b0;
            invalid_flag <= 1'b0;
            done_q       <= 1'b0;
        end else if (zeroize) begin
            bound        <= '0;
            data_valid   <= 1'b0;
            invalid_flag <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            // Memory data follows the read strobe by one cycle
            data_valid <= mem_rd_en;
            done_q     <= ctrl_done;
            if (norm_check_enable) begin
                bound        <= norm_check_pkg::mode_bound(check_mode);
                invalid_flag <= 1'b0;
            end else if (data_valid && |lane_hit) begin
                invalid_flag <= 1'b1;
            end
        end
    end

    // The last word is compared in the ctrl_done cycle, so the registered
    // done sees the flag with every word folded in
    assign norm_check_done    = done_q;
    assign norm_check_invalid = invalid_flag;

endmodule

// File: tb.f
src/norm_check_pkg.sv
src/norm_check_ctrl.sv
src/coeff_mem.sv
src/norm_check_unit.sv
src/norm_check_top.sv
bench/norm_check_assert.sv
bench/norm_check_tb.sv
